// File: hdl/sonata_io_macros.svh
// ##############################
// Board I/O constants
// Bus widths, register map and cycle counts
// ##############################
`ifndef SONATA_IO_MACROS_SVH
`define SONATA_IO_MACROS_SVH

`define SONATA_IO_ADDR_W     8      // APB address bits
`define SONATA_IO_DATA_W     32     // APB data bits
`define SONATA_IO_SEL_BIT    4      // Low is GPIO, high is RS-485

`define GPIO_IN_OFFSET       8'h00  // Switches, read only
`define GPIO_OUT_OFFSET      8'h04  // User LEDs
`define RS485_CTRL_OFFSET    8'h10  // Bit 0 tx enable, bit 1 rx enable
`define RS485_STATUS_OFFSET  8'h14  // State code, read only

`define RESET_HOLD_CYCLES    16     // Clean cycles before release
`define SYNC_STAGES          2      // Switch synchroniser depth
// 100 ns at 40 MHz rounded up plus one
`define RS485_SWITCH_CYCLES  5
`define RS485_END_CYCLES     5      // Driver hold after last bit

`endif

// File: hdl/sonata_io_pkg.sv
// ##############################
// Board I/O types
// Bus vectors and FSM encodings
// ##############################
`default_nettype none

`include "sonata_io_macros.svh"

package sonata_io_pkg;

  typedef logic [`SONATA_IO_ADDR_W-1:0] apb_addr_t;
  typedef logic [`SONATA_IO_DATA_W-1:0] apb_data_t;

  typedef logic [7:0]  led_t;       // User LEDs
  // LSB up: user switches, nav, select, card detect
  typedef logic [16:0] sw_t;
  typedef logic [4:0]  hold_cnt_t;  // Wide enough to reach 16

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_SETUP,
    ARB_ACCESS
  } arb_state_e;

  // Codes are visible through STATUS
  typedef enum logic [1:0] {
    RS_IDLE    = 2'd0,
    RS_TURN_ON = 2'd1,
    RS_SEND    = 2'd2,
    RS_DRAIN   = 2'd3
  } rs485_state_e;

endpackage

`default_nettype wire

// File: hdl/rst_ctrl.sv
// ##############################
// Reset controller
// Stretches system reset past button and PLL lock
// ##############################
`default_nettype none

`include "sonata_io_macros.svh"

module rst_ctrl
  import sonata_io_pkg::*;
(
  input  logic clk_sys_i,
  input  logic reset_i,
  input  logic rst_btn_i,     // Button pressed
  input  logic pll_locked_i,
  output logic rst_sys_o,     // Active high system reset
  output logic led_bootok_o
);

  hold_cnt_t hold_cnt_q;
  logic      hold_q;          // Still counting clean cycles
  logic      fault;

  // Anything that must keep the system down
  assign fault = reset_i || rst_btn_i || !pll_locked_i;

  always_ff @(posedge clk_sys_i) begin
    if (fault) begin
      hold_cnt_q <= '0;       // Restart on any glitch
      hold_q     <= 1'b1;
    end else begin
      if (hold_cnt_q != hold_cnt_t'(`RESET_HOLD_CYCLES))
        hold_cnt_q <= hold_cnt_q + 1'b1;  // Saturate at the hold count
      hold_q <= (hold_cnt_q < hold_cnt_t'(`RESET_HOLD_CYCLES - 1));
    end
  end

  assign rst_sys_o    = fault || hold_q;  // Immediate on fault
  assign led_bootok_o = !rst_sys_o;       // Lit once running

endmodule

`default_nettype wire

// File: hdl/apb_arbiter.sv
// ##############################
// APB arbiter
// Round-robin of host and debug onto the peers
// ##############################
`default_nettype none

`include "sonata_io_macros.svh"

module apb_arbiter
  import sonata_io_pkg::*;
(
  input  logic      clk_sys_i,
  input  logic      reset_i,
  // Host requester
  input  logic      host_psel_i,
  input  logic      host_penable_i,
  input  logic      host_pwrite_i,
  input  apb_addr_t host_paddr_i,
  input  apb_data_t host_pwdata_i,
  output apb_data_t host_prdata_o,
  output logic      host_pready_o,
  output logic      host_pslverr_o,
  // Debug requester
  input  logic      dbg_psel_i,
  input  logic      dbg_penable_i,
  input  logic      dbg_pwrite_i,
  input  apb_addr_t dbg_paddr_i,
  input  apb_data_t dbg_pwdata_i,
  output apb_data_t dbg_prdata_o,
  output logic      dbg_pready_o,
  output logic      dbg_pslverr_o,
  // Shared completer bus
  output logic      gpio_psel_o,
  output logic      rs_psel_o,
  output logic      penable_o,
  output logic      pwrite_o,
  output apb_addr_t paddr_o,
  output apb_data_t pwdata_o,
  // Peer responses
  input  apb_data_t gpio_prdata_i,
  input  logic      gpio_pslverr_i,
  input  apb_data_t rs_prdata_i,
  input  logic      rs_pslverr_i
);

  arb_state_e state_q, state_d;
  logic       gnt_dbg_q;      // Current owner, 1 is debug
  logic       last_dbg_q;     // Winner of the last contested grant
  logic       pick_dbg;
  logic       any_req;
  logic       req_penable;    // Owner reached its access phase
  logic       sel_rs;
  apb_data_t  resp_data;
  logic       resp_err;

  assign any_req = host_psel_i || dbg_psel_i;

  // Priority only flips when both ask at once
  always_comb begin
    if (host_psel_i && dbg_psel_i)
      pick_dbg = !last_dbg_q;
    else
      pick_dbg = dbg_psel_i;
  end

  assign req_penable = gnt_dbg_q ? dbg_penable_i : host_penable_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE:   if (any_req) state_d = ARB_SETUP;
      ARB_SETUP:  if (req_penable) state_d = ARB_ACCESS;  // Stretch setup if late
      ARB_ACCESS: state_d = ARB_IDLE;   // Zero wait peers
      default:    state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      state_q    <= ARB_IDLE;
      gnt_dbg_q  <= 1'b0;
      last_dbg_q <= 1'b1;     // Host wins first contest
    end else begin
      state_q <= state_d;
      if (state_q == ARB_IDLE && any_req) begin
        gnt_dbg_q <= pick_dbg;  // Held until the access ends
        if (host_psel_i && dbg_psel_i)
          last_dbg_q <= pick_dbg;
      end
    end
  end

  // Owner's transfer replayed to the peer
  assign paddr_o   = gnt_dbg_q ? dbg_paddr_i  : host_paddr_i;
  assign pwdata_o  = gnt_dbg_q ? dbg_pwdata_i : host_pwdata_i;
  assign pwrite_o  = gnt_dbg_q ? dbg_pwrite_i : host_pwrite_i;
  assign penable_o = (state_q == ARB_ACCESS);

  assign sel_rs      = paddr_o[`SONATA_IO_SEL_BIT];
  assign gpio_psel_o = (state_q != ARB_IDLE) && !sel_rs;
  assign rs_psel_o   = (state_q != ARB_IDLE) && sel_rs;

  assign resp_data = sel_rs ? rs_prdata_i  : gpio_prdata_i;
  assign resp_err  = sel_rs ? rs_pslverr_i : gpio_pslverr_i;

  // Completion goes to the owner only
  assign host_pready_o  = penable_o && !gnt_dbg_q;
  assign dbg_pready_o   = penable_o && gnt_dbg_q;
  assign host_prdata_o  = host_pready_o ? resp_data : '0;
  assign dbg_prdata_o   = dbg_pready_o ? resp_data : '0;
  assign host_pslverr_o = host_pready_o && resp_err;
  assign dbg_pslverr_o  = dbg_pready_o && resp_err;

endmodule

`default_nettype wire

// File: hdl/gpio_regs.sv
// ##############################
// GPIO registers
// Synchronised switches and user LEDs on APB
// ##############################
`default_nettype none

`include "sonata_io_macros.svh"

module gpio_regs
  import sonata_io_pkg::*;
(
  input  logic       clk_sys_i,
  input  logic       reset_i,
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  apb_addr_t  paddr_i,
  input  apb_data_t  pwdata_i,
  output apb_data_t  prdata_o,
  output logic       pslverr_o,
  input  logic [4:0] nav_sw_ni,      // Joystick, active low
  input  logic [7:0] usr_sw_ni,      // User switches, active low
  input  logic [2:0] sel_sw_ni,      // Select switches, active low
  input  logic       microsd_det_i,  // Card detect
  output led_t       usr_led_o
);

  sw_t  sw_raw;
  sw_t  sw_sync_q [`SYNC_STAGES];
  led_t led_q;
  logic access;
  logic addr_ok;                     // Offset is mapped
  logic wr_ok;                       // Offset is writable

  // Pull-ups on the pads, so a closed switch reads low
  assign sw_raw = {microsd_det_i, ~sel_sw_ni, ~nav_sw_ni, ~usr_sw_ni};

  // Plain shift chain
  always_ff @(posedge clk_sys_i) begin
    sw_sync_q[0] <= sw_raw;
    for (int i = 1; i < `SYNC_STAGES; i++)
      sw_sync_q[i] <= sw_sync_q[i-1];
  end

  always_comb begin
    prdata_o = '0;
    addr_ok  = 1'b0;
    wr_ok    = 1'b0;
    case (paddr_i)
      `GPIO_IN_OFFSET: begin
        prdata_o = apb_data_t'(sw_sync_q[`SYNC_STAGES-1]);
        addr_ok  = 1'b1;
      end
      `GPIO_OUT_OFFSET: begin
        prdata_o = apb_data_t'(led_q);
        addr_ok  = 1'b1;
        wr_ok    = 1'b1;
      end
      default: prdata_o = '0;        // Unmapped reads as zero
    endcase
  end

  assign access    = psel_i && penable_i;
  assign pslverr_o = access && (!addr_ok || (pwrite_i && !wr_ok));

  always_ff @(posedge clk_sys_i) begin
    if (reset_i)
      led_q <= '0;                   // LEDs dark
    else if (access && pwrite_i && wr_ok)
      led_q <= led_t'(pwdata_i);     // Low byte only
  end

  assign usr_led_o = led_q;

endmodule

`default_nettype wire

// File: hdl/rs485_ctrl.sv
// ##############################
// RS-485 direction control
// Driver enable sequencing with APB registers
// ##############################
`default_nettype none

`include "sonata_io_macros.svh"

module rs485_ctrl
  import sonata_io_pkg::*;
(
  input  logic      clk_sys_i,
  input  logic      reset_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  output apb_data_t prdata_o,
  output logic      pslverr_o,
  input  logic      rs485_tx_i,   // Serial data to send
  output logic      rs485_rx_o,   // Serial data received
  input  logic      rs485_ro_i,   // Transceiver receiver out
  output logic      rs485_di_o,   // Transceiver driver in
  output logic      rs485_de_o,   // Driver enable
  output logic      rs485_ren_o   // Receiver enable, active low
);

  rs485_state_e state_q;
  logic [3:0]   delay_q;          // Cycles spent in a timed state
  logic         tx_en_q;
  logic         rx_en_q;
  logic         tx_en_d;
  logic         access;
  logic         ctrl_wr;
  logic         addr_ok;
  logic         wr_ok;
  logic         rx_on;

  assign access  = psel_i && penable_i;
  assign ctrl_wr = access && pwrite_i && (paddr_i == `RS485_CTRL_OFFSET);

  // FSM reacts in the same edge as the register
  assign tx_en_d = ctrl_wr ? pwdata_i[0] : tx_en_q;

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      tx_en_q <= 1'b0;
      rx_en_q <= 1'b0;
    end else if (ctrl_wr) begin
      tx_en_q <= pwdata_i[0];
      rx_en_q <= pwdata_i[1];
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      state_q <= RS_IDLE;
      delay_q <= '0;
    end else begin
      case (state_q)
        RS_IDLE: begin
          delay_q <= '0;
          if (tx_en_d)
            state_q <= RS_TURN_ON;  // Give the driver time to switch
        end
        RS_TURN_ON: begin
          if (delay_q == 4'(`RS485_SWITCH_CYCLES - 1))
            state_q <= RS_SEND;
          else
            delay_q <= delay_q + 1'b1;
        end
        RS_SEND: begin
          delay_q <= '0;
          if (!tx_en_d)
            state_q <= RS_DRAIN;    // Last bit may still be on the wire
        end
        RS_DRAIN: begin
          if (delay_q == 4'(`RS485_END_CYCLES - 1))
            state_q <= RS_IDLE;
          else
            delay_q <= delay_q + 1'b1;
        end
        default: state_q <= RS_IDLE;
      endcase
    end
  end

  // Line idles high outside of sending
  assign rs485_de_o  = (state_q != RS_IDLE);
  assign rs485_di_o  = (state_q == RS_SEND) ? rs485_tx_i : 1'b1;
  assign rx_on       = (state_q == RS_IDLE) && rx_en_q;  // Half duplex
  assign rs485_ren_o = !rx_on;
  assign rs485_rx_o  = rx_on ? rs485_ro_i : 1'b1;

  always_comb begin
    prdata_o = '0;
    addr_ok  = 1'b0;
    wr_ok    = 1'b0;
    case (paddr_i)
      `RS485_CTRL_OFFSET: begin
        prdata_o = apb_data_t'({rx_en_q, tx_en_q});
        addr_ok  = 1'b1;
        wr_ok    = 1'b1;
      end
      `RS485_STATUS_OFFSET: begin
        prdata_o = apb_data_t'(state_q);  // Raw state code
        addr_ok  = 1'b1;
      end
      default: prdata_o = '0;
    endcase
  end

  assign pslverr_o = access && (!addr_ok || (pwrite_i && !wr_ok));

endmodule

`default_nettype wire

// File: hdl/sonata_io_top.sv
// ##############################
// Board I/O top
// Reset, APB arbiter, GPIO and RS-485
// ##############################
`default_nettype none

module sonata_io_top
  import sonata_io_pkg::*;
(
  input  logic       clk_sys_i,
  input  logic       reset_i,
  input  logic       rst_btn_i,
  input  logic       pll_locked_i,
  // Host CPU port
  input  logic       host_psel_i,
  input  logic       host_penable_i,
  input  logic       host_pwrite_i,
  input  apb_addr_t  host_paddr_i,
  input  apb_data_t  host_pwdata_i,
  output apb_data_t  host_prdata_o,
  output logic       host_pready_o,
  output logic       host_pslverr_o,
  // Debug port
  input  logic       dbg_psel_i,
  input  logic       dbg_penable_i,
  input  logic       dbg_pwrite_i,
  input  apb_addr_t  dbg_paddr_i,
  input  apb_data_t  dbg_pwdata_i,
  output apb_data_t  dbg_prdata_o,
  output logic       dbg_pready_o,
  output logic       dbg_pslverr_o,
  // Board pins
  input  logic [4:0] nav_sw_ni,
  input  logic [7:0] usr_sw_ni,
  input  logic [2:0] sel_sw_ni,
  input  logic       microsd_det_i,
  output led_t       usr_led_o,
  output logic       led_bootok_o,
  input  logic       rs485_tx_i,
  output logic       rs485_rx_o,
  input  logic       rs485_ro_i,
  output logic       rs485_di_o,
  output logic       rs485_de_o,
  output logic       rs485_ren_o
);

  logic      rst_sys;               // Stretched system reset
  logic      gpio_psel;
  logic      rs_psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t gpio_prdata;
  logic      gpio_pslverr;
  apb_data_t rs_prdata;
  logic      rs_pslverr;

  rst_ctrl u_rst_ctrl (
    .clk_sys_i, .reset_i, .rst_btn_i, .pll_locked_i,
    .rst_sys_o    (rst_sys),
    .led_bootok_o
  );

  apb_arbiter u_apb_arbiter (
    .clk_sys_i, .reset_i(rst_sys),
    .host_psel_i, .host_penable_i, .host_pwrite_i, .host_paddr_i, .host_pwdata_i,
    .host_prdata_o, .host_pready_o, .host_pslverr_o,
    .dbg_psel_i, .dbg_penable_i, .dbg_pwrite_i, .dbg_paddr_i, .dbg_pwdata_i,
    .dbg_prdata_o, .dbg_pready_o, .dbg_pslverr_o,
    .gpio_psel_o(gpio_psel), .rs_psel_o(rs_psel), .penable_o(penable),
    .pwrite_o(pwrite), .paddr_o(paddr), .pwdata_o(pwdata),
    .gpio_prdata_i(gpio_prdata), .gpio_pslverr_i(gpio_pslverr),
    .rs_prdata_i(rs_prdata), .rs_pslverr_i(rs_pslverr)
  );

  gpio_regs u_gpio_regs (
    .clk_sys_i, .reset_i(rst_sys),
    .psel_i(gpio_psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata),
    .prdata_o(gpio_prdata), .pslverr_o(gpio_pslverr),
    .nav_sw_ni, .usr_sw_ni, .sel_sw_ni, .microsd_det_i, .usr_led_o
  );

  rs485_ctrl u_rs485_ctrl (
    .clk_sys_i, .reset_i(rst_sys),
    .psel_i(rs_psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata),
    .prdata_o(rs_prdata), .pslverr_o(rs_pslverr),
    .rs485_tx_i, .rs485_rx_o, .rs485_ro_i, .rs485_di_o, .rs485_de_o, .rs485_ren_o
  );

endmodule

`default_nettype wire

// File: sim/sonata_io_properties.sv
// ##############################
// Bus and RS-485 assertions
// Bound into the arbiter and the RS-485 block
// ##############################
`default_nettype none

module sonata_io_properties
  import sonata_io_pkg::*;
(
  input logic       clk_i,
  input logic       rst_i,
  input logic       host_pready_i,
  input logic       dbg_pready_i,
  input logic       gpio_psel_i,
  input logic       rs_psel_i,
  input logic       de_i,
  input logic [1:0] state_i        // RS-485 state code
);

  int fail_count = 0;              // Assertion failures so far

  // Only one owner completes at a time
  a_pready_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(host_pready_i && dbg_pready_i))
    else begin
      $error("both pready outputs high");
      fail_count++;
    end

  a_psel_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(gpio_psel_i && rs_psel_i))
    else begin
      $error("both peers selected");
      fail_count++;
    end

  // Driver must be on in every active state
  a_de_active: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_i != 2'(RS_IDLE)) |-> de_i)
    else begin
      $error("driver enable low outside idle");
      fail_count++;
    end

endmodule

bind apb_arbiter sonata_io_properties arb_props (
  .clk_i(clk_sys_i), .rst_i(reset_i),
  .host_pready_i(host_pready_o), .dbg_pready_i(dbg_pready_o),
  .gpio_psel_i(gpio_psel_o), .rs_psel_i(rs_psel_o),
  .de_i(1'b0), .state_i(2'b00)
);

bind rs485_ctrl sonata_io_properties rs_props (
  .clk_i(clk_sys_i), .rst_i(reset_i),
  .host_pready_i(1'b0), .dbg_pready_i(1'b0),
  .gpio_psel_i(1'b0), .rs_psel_i(1'b0),
  .de_i(rs485_de_o), .state_i(state_q)
);

`default_nettype wire

// File: sim/sonata_io_checker.sv
// ##############################
// Board I/O checker
// Watches DUT ports, compares and counts
// ##############################
`default_nettype none

module sonata_io_checker
  import sonata_io_pkg::*;
(
  input logic      clk_i,
  input logic      host_pready_i,
  input logic      host_pslverr_i,
  input apb_data_t host_prdata_i,
  input logic      dbg_pready_i,
  input logic      dbg_pslverr_i,
  input apb_data_t dbg_prdata_i,
  input led_t      usr_led_i,
  input logic      led_bootok_i,
  input logic      rs485_de_i,
  input logic      rs485_di_i,
  input logic      rs485_ren_i,
  input logic      rs485_rx_i
);

  int        err_count = 0;
  int        test_count = 0;
  int        test_errs = 0;      // Errors in the current test
  apb_data_t host_rdata_q;
  apb_data_t dbg_rdata_q;
  logic      host_err_q;
  logic      dbg_err_q;
  string     done_order = "";    // H or D per completion

  // Capture each completion mid-cycle
  always @(negedge clk_i) begin
    if (host_pready_i) begin
      host_rdata_q = host_prdata_i;
      host_err_q   = host_pslverr_i;
      done_order   = {done_order, "H"};
    end
    if (dbg_pready_i) begin
      dbg_rdata_q = dbg_prdata_i;
      dbg_err_q   = dbg_pslverr_i;
      done_order  = {done_order, "D"};
    end
  end

  task automatic compare(input string name, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %h, actual %h", name, what, exp, act);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic check_read(input string name, input bit dbg,
                            input apb_data_t exp_data, input logic exp_err);
    compare(name, "prdata", exp_data, dbg ? dbg_rdata_q : host_rdata_q);
    compare(name, "pslverr", 32'(exp_err), 32'(dbg ? dbg_err_q : host_err_q));
  endtask

  task automatic check_err(input string name, input bit dbg, input logic exp_err);
    compare(name, "pslverr", 32'(exp_err), 32'(dbg ? dbg_err_q : host_err_q));
  endtask

  task automatic check_led(input string name, input led_t exp);
    compare(name, "usr_led", 32'(exp), 32'(usr_led_i));
  endtask

  task automatic check_bootok(input string name, input logic exp);
    compare(name, "led_bootok", 32'(exp), 32'(led_bootok_i));
  endtask

  // Packed as de, di, ren, rx
  task automatic check_rs485(input string name, input logic [3:0] exp);
    compare(name, "rs485 de/di/ren/rx", 32'(exp),
            32'({rs485_de_i, rs485_di_i, rs485_ren_i, rs485_rx_i}));
  endtask

  task automatic clear_order();
    done_order = "";
  endtask

  task automatic check_order(input string name, input string exp);
    if (done_order != exp) begin
      $display("[ERROR] %s: completion order expected %s, actual %s",
               name, exp, done_order);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic report_failure(input string name, input string msg);
    $display("%s: %s", name, msg);
    err_count++;
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0)
      $display("test %-20s ok", name);
    else
      $display("test %-20s failed with %0d errors", name, test_errs);
    test_count++;
    test_errs = 0;
  endtask

endmodule

`default_nettype wire

// File: sim/tb_sonata_io.sv
// ##############################
// Board I/O testbench
// File driven APB and pin stimulus
// ##############################
`default_nettype none

`include "sonata_io_macros.svh"

module tb_sonata_io
  import sonata_io_pkg::*;
;

  logic       clk_sys_i = 1'b0;
  logic       reset_i, rst_btn_i, pll_locked_i;
  logic       host_psel_i, host_penable_i, host_pwrite_i;
  apb_addr_t  host_paddr_i;
  apb_data_t  host_pwdata_i, host_prdata_o;
  logic       host_pready_o, host_pslverr_o;
  logic       dbg_psel_i, dbg_penable_i, dbg_pwrite_i;
  apb_addr_t  dbg_paddr_i;
  apb_data_t  dbg_pwdata_i, dbg_prdata_o;
  logic       dbg_pready_o, dbg_pslverr_o;
  logic [4:0] nav_sw_ni;
  logic [7:0] usr_sw_ni;
  logic [2:0] sel_sw_ni;
  logic       microsd_det_i;
  led_t       usr_led_o;
  logic       led_bootok_o;
  logic       rs485_tx_i, rs485_rx_o, rs485_ro_i;
  logic       rs485_di_o, rs485_de_o, rs485_ren_o;

  string       names[$], ops[$], reqs[$];
  logic [31:0] addrs[$], datas[$], exps[$];
  int          cycles = 0;
  int          limit = 0;          // Zero until the stimulus is loaded
  logic [31:0] rng_state = 32'hc0d0;

  sonata_io_top sonata_io_top_inst (.*);

  sonata_io_checker checker_inst (
    .clk_i(clk_sys_i),
    .host_pready_i(host_pready_o), .host_pslverr_i(host_pslverr_o),
    .host_prdata_i(host_prdata_o),
    .dbg_pready_i(dbg_pready_o), .dbg_pslverr_i(dbg_pslverr_o),
    .dbg_prdata_i(dbg_prdata_o),
    .usr_led_i(usr_led_o), .led_bootok_i(led_bootok_o),
    .rs485_de_i(rs485_de_o), .rs485_di_i(rs485_di_o),
    .rs485_ren_i(rs485_ren_o), .rs485_rx_i(rs485_rx_o)
  );

  always #4 clk_sys_i = ~clk_sys_i;  // Period 8

  always @(posedge clk_sys_i) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic load_stimulus();
    int    fd;
    int    n;
    string line, nm, op, rq;
    logic [31:0] a, d, e;
    fd = $fopen("sim/sonata_io_stimulus.txt", "r");
    if (fd == 0) begin
      checker_inst.report_failure("stimulus", "could not open the stimulus file");
    end else begin
      while ($fgets(line, fd) > 0) begin
        n = 0;
        if (line.len() > 1 && line.getc(0) != "#")
          n = $sscanf(line, "%s %s %s %h %h %h", nm, op, rq, a, d, e);
        if (n == 6) begin
          names.push_back(nm);
          ops.push_back(op);
          reqs.push_back(rq);
          addrs.push_back(a);
          datas.push_back(d);
          exps.push_back(e);
        end
      end
      $fclose(fd);
    end
  endtask

  // One APB transfer on the chosen port, returns after completion
  task automatic apb_xfer(input bit dbg, input bit wr, input apb_addr_t addr,
                          input apb_data_t wdata);
    @(posedge clk_sys_i);
    #1;
    if (dbg) begin
      dbg_psel_i   = 1'b1;
      dbg_pwrite_i = wr;
      dbg_paddr_i  = addr;
      dbg_pwdata_i = wdata;
    end else begin
      host_psel_i   = 1'b1;
      host_pwrite_i = wr;
      host_paddr_i  = addr;
      host_pwdata_i = wdata;
    end
    @(posedge clk_sys_i);
    #1;
    if (dbg) dbg_penable_i = 1'b1;
    else host_penable_i = 1'b1;
    do @(negedge clk_sys_i); while (!(dbg ? dbg_pready_o : host_pready_o));
    @(posedge clk_sys_i);
    #1;
    if (dbg) begin
      dbg_psel_i    = 1'b0;
      dbg_penable_i = 1'b0;
    end else begin
      host_psel_i    = 1'b0;
      host_penable_i = 1'b0;
    end
  endtask

  task automatic reset_step(input string nm, input int hold, input int exp);
    int n;
    n = 0;
    @(posedge clk_sys_i);
    #1 rst_btn_i = 1'b1;
    repeat (hold) begin
      @(negedge clk_sys_i);
      checker_inst.check_bootok(nm, 1'b0);
    end
    @(posedge clk_sys_i);
    #1 rst_btn_i = 1'b0;
    do begin
      @(posedge clk_sys_i);
      n++;
      @(negedge clk_sys_i);
    end while (!led_bootok_o && n < 100);
    checker_inst.compare(nm, "cycles to boot", exp, n);
    checker_inst.check_led(nm, 8'h00);
    checker_inst.check_rs485(nm, 4'b0111);  // Driver off, receiver off
  endtask

  task automatic tx_step(input string nm, input apb_addr_t addr, input apb_data_t ctrl,
                         input apb_data_t exp_status);
    apb_xfer(1'b0, 1'b1, addr, ctrl);
    checker_inst.check_err(nm, 1'b0, 1'b0);
    repeat (`RS485_SWITCH_CYCLES) begin       // Turn-on, tx held low
      @(negedge clk_sys_i);
      checker_inst.check_rs485(nm, 4'b1111);
    end
    for (int k = 0; k < 8; k++) begin
      @(posedge clk_sys_i);
      rng_state = xorshift(rng_state);
      #1 rs485_tx_i = (k == 0) ? 1'b0 : rng_state[0];
      @(negedge clk_sys_i);
      checker_inst.check_rs485(nm, {1'b1, rs485_tx_i, 2'b11});
    end
    apb_xfer(1'b0, 1'b0, `RS485_STATUS_OFFSET, '0);
    checker_inst.check_read(nm, 1'b0, exp_status, 1'b0);
    apb_xfer(1'b0, 1'b1, addr, '0);
    repeat (`RS485_END_CYCLES) begin
      @(negedge clk_sys_i);
      checker_inst.check_rs485(nm, 4'b1111);
    end
    @(negedge clk_sys_i);
    checker_inst.check_rs485(nm, 4'b0111);
    apb_xfer(1'b0, 1'b0, `RS485_STATUS_OFFSET, '0);
    checker_inst.check_read(nm, 1'b0, 32'd0, 1'b0);  // Back to idle
  endtask

  task automatic rx_step(input string nm, input bit dbg, input apb_addr_t addr,
                         input apb_data_t ctrl, input logic exp_ren);
    apb_xfer(dbg, 1'b1, addr, ctrl);
    checker_inst.check_err(nm, dbg, 1'b0);
    @(negedge clk_sys_i);
    checker_inst.check_rs485(nm, {2'b01, exp_ren, 1'b1});
    @(posedge clk_sys_i);
    #1 rs485_ro_i = 1'b0;
    @(negedge clk_sys_i);
    checker_inst.check_rs485(nm, {2'b01, exp_ren, 1'b0});
    @(posedge clk_sys_i);
    #1 rs485_ro_i = 1'b1;
    @(negedge clk_sys_i);
    checker_inst.check_rs485(nm, {2'b01, exp_ren, 1'b1});
  endtask

  task automatic run_step(input int i);
    string nm;
    bit    dbg;
    nm  = names[i];
    dbg = (reqs[i] == "dbg");
    case (ops[i])
      "reset": reset_step(nm, datas[i], exps[i]);
      "switches": begin
        @(posedge clk_sys_i);
        #1 {microsd_det_i, sel_sw_ni, nav_sw_ni, usr_sw_ni} = datas[i][16:0];
        repeat (`SYNC_STAGES + 2) @(posedge clk_sys_i);
        apb_xfer(1'b0, 1'b0, addrs[i], '0);
        checker_inst.check_read(nm, 1'b0, exps[i], 1'b0);
      end
      "read", "rderr": begin
        apb_xfer(dbg, 1'b0, addrs[i], '0);
        checker_inst.check_read(nm, dbg, exps[i], ops[i] == "rderr");
      end
      "write", "wrerr": begin
        apb_xfer(dbg, 1'b1, addrs[i], datas[i]);
        checker_inst.check_err(nm, dbg, ops[i] == "wrerr");
        checker_inst.check_led(nm, exps[i][7:0]);
      end
      "dual": begin
        checker_inst.clear_order();
        fork
          apb_xfer(1'b0, 1'b0, addrs[i], '0);
          apb_xfer(1'b1, 1'b0, addrs[i], '0);
        join
        checker_inst.check_read(nm, 1'b0, exps[i], 1'b0);
        checker_inst.check_read(nm, 1'b1, exps[i], 1'b0);
        checker_inst.check_order(nm, datas[i][0] ? "DH" : "HD");
      end
      "tx": tx_step(nm, addrs[i], datas[i], exps[i]);
      "rx": rx_step(nm, dbg, addrs[i], datas[i], exps[i][0]);
      default: checker_inst.report_failure(nm, "unknown operation in stimulus file");
    endcase
    checker_inst.finish_test(nm);
  endtask

  initial begin
    int errors;                    // Checker and assertion failures
    reset_i = 1'b1;
    rst_btn_i = 1'b0;
    pll_locked_i = 1'b1;
    {host_psel_i, host_penable_i, host_pwrite_i} = 3'b000;
    {dbg_psel_i, dbg_penable_i, dbg_pwrite_i} = 3'b000;
    host_paddr_i = '0;
    host_pwdata_i = '0;
    dbg_paddr_i = '0;
    dbg_pwdata_i = '0;
    {microsd_det_i, sel_sw_ni, nav_sw_ni, usr_sw_ni} = 17'h1ffff;  // All open
    rs485_tx_i = 1'b0;
    rs485_ro_i = 1'b1;
    load_stimulus();
    limit = names.size() * 40 + `RESET_HOLD_CYCLES + 20;
    repeat (2) @(posedge clk_sys_i);
    #1 reset_i = 1'b0;
    while (!led_bootok_o) @(negedge clk_sys_i);  // Wait for boot
    for (int i = 0; i < names.size(); i++)
      run_step(i);
    errors = checker_inst.err_count
             + sonata_io_top_inst.u_apb_arbiter.arb_props.fail_count
             + sonata_io_top_inst.u_rs485_ctrl.rs_props.fail_count;
    $display("Tests: %0d, errors: %0d", checker_inst.test_count, errors);
    if (errors == 0 && names.size() > 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/sonata_io_pkg.sv
hdl/rst_ctrl.sv
hdl/apb_arbiter.sv
hdl/gpio_regs.sv
hdl/rs485_ctrl.sv
hdl/sonata_io_top.sv
sim/sonata_io_properties.sv
sim/sonata_io_checker.sv
sim/tb_sonata_io.sv

// File: sim/sonata_io_stimulus.txt
# name op requester addr data expected, all numbers hex
# data: button hold, switch pins, write data or pair order (1 is debug first)
reset_stretch      reset    host 00 6     10
sw_pattern_a       switches host 00 1A5F0 15A0F
sw_all_closed      switches host 00 00000 0FFFF
sw_all_open        switches host 00 1FFFF 10000
led_write_dbg      write    dbg  04 A5    A5
led_read_host      read     host 04 0     A5
led_write_host     write    host 04 3C    3C
led_read_dbg       read     dbg  04 0     3C
dual_host_first    dual     both 00 0     10000
dual_dbg_first     dual     both 04 1     3C
rs485_send         tx       host 10 1     2
rs485_rx_follow    rx       dbg  10 2     0
err_read_unmapped  rderr    host 08 0     0
err_write_status   wrerr    dbg  14 7     3C
err_write_gpio_in  wrerr    host 00 FF    3C
status_after_err   read     host 14 0     0
ctrl_after_err     read     dbg  10 0     2
led_after_err      read     host 04 0     3C
